//--- design/loc_regfile.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module loc_regfile
   import umi_pkg::*;
(
   input  logic     clk,
   input  logic     nreset,
   input  loc_req_t req,
   output loc_rsp_t rsp
);

   localparam int IDX_W = $clog2(`REGFILE_DEPTH);

   // Word 0 is the fixed ID, no storage behind it
   logic [`UMI_DW-1:0] regs [1:`REGFILE_DEPTH-1];
   logic [IDX_W-1:0]   idx;

   assign idx = req.addr[`UMI_WORD_LSB +: IDX_W];

   //####################################################################
   // Write port
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 1; i < `REGFILE_DEPTH; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (req.write && (idx != '0))   // ID word drops writes
      begin
         regs[idx] <= req.wrdata;
      end
   end

   //####################################################################
   // Read port
   //####################################################################

   always_comb
   begin
      if (idx == '0)
      begin
         rsp.rddata = `UMI_ID_VALUE;
      end
      else
      begin
         rsp.rddata = regs[idx];
      end
      rsp.ready = 1'b1;                    // Never stalls
   end

endmodule

//--- design/loc_sram.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module loc_sram
   import umi_pkg::*;
(
   input  logic     clk,
   input  logic     nreset,
   input  loc_req_t req,
   output loc_rsp_t rsp
);

   localparam int IDX_W = $clog2(`SRAM_DEPTH);

   logic [`UMI_DW-1:0] mem [0:`SRAM_DEPTH-1];
   logic [IDX_W-1:0]   idx;
   logic               recover;   // High in the cycle after a write
   logic               wr_en;

   assign idx   = req.addr[`UMI_WORD_LSB +: IDX_W];
   assign wr_en = req.write & ~recover;   // Write blocked while recovering

   //####################################################################
   // Storage and recovery flag
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < `SRAM_DEPTH; i++)
         begin
            mem[i] <= '0;
         end
         recover <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            mem[idx] <= req.wrdata;
         end
         recover <= wr_en;                 // One stall cycle per write
      end
   end

   // Combinational read, ready drops during recovery
   always_comb
   begin
      rsp.rddata = mem[idx];
      rsp.ready  = ~recover;
   end

endmodule

//--- design/loc_target_combine.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module loc_target_combine
   import umi_pkg::*;
(
   input  loc_req_t loc_req,
   output loc_rsp_t loc_rsp,
   output loc_req_t regfile_req,
   output loc_req_t sram_req,
   input  loc_rsp_t regfile_rsp,
   input  loc_rsp_t sram_rsp
);

   // Region codes
   localparam logic [1:0] REGION_REGFILE = 2'd0;
   localparam logic [1:0] REGION_SRAM    = 2'd1;

   logic [1:0] region;
   logic       sel_regfile;
   logic       sel_sram;

   assign region      = loc_req.addr[`UMI_REGION_LSB +: 2];
   assign sel_regfile = (region == REGION_REGFILE);
   assign sel_sram    = (region == REGION_SRAM);

   // Address and data fan out, strobes only to the selected target
   always_comb
   begin
      regfile_req       = loc_req;
      regfile_req.write = loc_req.write & sel_regfile;
      regfile_req.read  = loc_req.read & sel_regfile;
      sram_req          = loc_req;
      sram_req.write    = loc_req.write & sel_sram;
      sram_req.read     = loc_req.read & sel_sram;
   end

   // Answer mux, unmapped regions read zero and never stall
   always_comb
   begin
      if (sel_regfile)
      begin
         loc_rsp = regfile_rsp;
      end
      else if (sel_sram)
      begin
         loc_rsp = sram_rsp;
      end
      else
      begin
         loc_rsp.rddata = '0;
         loc_rsp.ready  = 1'b1;
      end
   end

endmodule

//--- design/umi_config.svh
`ifndef UMI_CONFIG_SVH
`define UMI_CONFIG_SVH

// Packet field widths
`define UMI_CW 32
`define UMI_AW 64
`define UMI_DW 64

// Opcodes
`define UMI_REQ_WRITE 8'h03
`define UMI_REQ_READ  8'h01
`define UMI_RESP_READ 8'h02

// Region select is dstaddr[13:12], word index starts at bit 3
`define UMI_REGION_LSB 12
`define UMI_WORD_LSB   3

// Target sizes in 64-bit words
`define REGFILE_DEPTH 16
`define SRAM_DEPTH    64

// Register word 0 contents
`define UMI_ID_VALUE 64'h0000_0001_5EED_CAFE

`endif

//--- design/umi_endpoint.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module umi_endpoint
   import umi_pkg::*;
(
   input  logic      clk,
   input  logic      nreset,
   // Device request side
   input  logic      udev_req_valid,
   input  umi_req_t  udev_req,
   output logic      udev_req_ready,
   // Device response side
   output logic      udev_resp_valid,
   output umi_resp_t udev_resp,
   input  logic      udev_resp_ready,
   // Local bus
   output loc_req_t  loc_req,
   input  loc_rsp_t  loc_rsp
);

   umi_cmd_t           req_fields;    // Unpacked request command
   logic               is_write;
   logic               read_accept;   // Read taken this cycle

   // Captured response payload
   logic [`UMI_DW-1:0] rsp_data_q;
   logic [`UMI_AW-1:0] rsp_dst_q;
   logic [3:0]         rsp_size_q;
   logic [19:0]        rsp_opts_q;

   //####################################################################
   // Request unpack
   //####################################################################

   assign req_fields = umi_unpack_cmd(udev_req.cmd);
   assign is_write   = (req_fields.opcode == `UMI_REQ_WRITE);  // Anything else reads

   // Strobes only while a request is present and the response side can take it
   always_comb
   begin
      loc_req.addr   = udev_req.dstaddr;
      loc_req.wrdata = udev_req.data;
      loc_req.write  = udev_req_valid & udev_resp_ready & is_write;
      loc_req.read   = udev_req_valid & udev_resp_ready & ~is_write;
   end

   // Stall on busy target or blocked response
   assign udev_req_ready = loc_rsp.ready & udev_resp_ready;

   // Strobe already carries resp_ready, so target ready completes the handshake
   assign read_accept = loc_req.read & loc_rsp.ready;

   //####################################################################
   // Response valid
   //####################################################################

   // Set on accepted read, clear once taken, new read overrides clear
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         udev_resp_valid <= 1'b0;
      end
      else if (read_accept)
      begin
         udev_resp_valid <= 1'b1;
      end
      else if (udev_resp_valid && udev_resp_ready)
      begin
         udev_resp_valid <= 1'b0;
      end
   end

   //####################################################################
   // Response payload
   //####################################################################

   // Capture read data with return routing info
   always_ff @(posedge clk)
   begin
      if (read_accept)
      begin
         rsp_data_q <= loc_rsp.rddata;
         rsp_dst_q  <= udev_req.srcaddr;    // Reply goes back to requester
         rsp_size_q <= req_fields.size;
         rsp_opts_q <= req_fields.options;
      end
   end

   // Pack the read response
   always_comb
   begin
      udev_resp.cmd     = umi_pack_cmd(`UMI_RESP_READ, rsp_size_q, rsp_opts_q);
      udev_resp.dstaddr = rsp_dst_q;
      udev_resp.srcaddr = '0;               // No source on responses
      udev_resp.data    = rsp_data_q;
   end

endmodule

//--- design/umi_mem_subsys.sv
`timescale 1ns/1ps

module umi_mem_subsys
   import umi_pkg::*;
(
   input  logic      clk,
   input  logic      nreset,
   // Request channel
   input  logic      udev_req_valid,
   input  umi_req_t  udev_req,
   output logic      udev_req_ready,
   // Response channel
   output logic      udev_resp_valid,
   output umi_resp_t udev_resp,
   input  logic      udev_resp_ready
);

   loc_req_t loc_req;       // Endpoint to combiner
   loc_rsp_t loc_rsp;
   loc_req_t regfile_req;   // Combiner to targets
   loc_rsp_t regfile_rsp;
   loc_req_t sram_req;
   loc_rsp_t sram_rsp;

   //####################################################################
   // Fabric endpoint
   //####################################################################

   umi_endpoint i_umi_endpoint (
      .clk             (clk),
      .nreset          (nreset),
      .udev_req_valid  (udev_req_valid),
      .udev_req        (udev_req),
      .udev_req_ready  (udev_req_ready),
      .udev_resp_valid (udev_resp_valid),
      .udev_resp       (udev_resp),
      .udev_resp_ready (udev_resp_ready),
      .loc_req         (loc_req),
      .loc_rsp         (loc_rsp)
   );

   // Region decode and answer merge
   loc_target_combine i_loc_target_combine (
      .loc_req     (loc_req),
      .loc_rsp     (loc_rsp),
      .regfile_req (regfile_req),
      .sram_req    (sram_req),
      .regfile_rsp (regfile_rsp),
      .sram_rsp    (sram_rsp)
   );

   //####################################################################
   // Targets
   //####################################################################

   loc_regfile i_loc_regfile (
      .clk    (clk),
      .nreset (nreset),
      .req    (regfile_req),
      .rsp    (regfile_rsp)
   );

   loc_sram i_loc_sram (
      .clk    (clk),
      .nreset (nreset),
      .req    (sram_req),
      .rsp    (sram_rsp)
   );

endmodule

//--- design/umi_pkg.sv
`include "umi_config.svh"

package umi_pkg;

   // Command word fields, opcode in the low byte
   typedef struct packed {
      logic [19:0] options;   // [31:12]
      logic [3:0]  size;      // [11:8]
      logic [7:0]  opcode;    // [7:0]
   } umi_cmd_t;

   // Request packet, 224 bits
   typedef struct packed {
      logic [`UMI_CW-1:0] cmd;
      logic [`UMI_AW-1:0] dstaddr;
      logic [`UMI_AW-1:0] srcaddr;
      logic [`UMI_DW-1:0] data;
   } umi_req_t;

   // Response uses the request layout
   typedef umi_req_t umi_resp_t;

   // Local bus toward the targets
   typedef struct packed {
      logic [`UMI_AW-1:0] addr;
      logic [`UMI_DW-1:0] wrdata;
      logic               write;
      logic               read;
   } loc_req_t;

   // Local bus answer from the targets
   typedef struct packed {
      logic [`UMI_DW-1:0] rddata;
      logic               ready;
   } loc_rsp_t;

   // Split a raw command into its fields
   function automatic umi_cmd_t umi_unpack_cmd(input logic [`UMI_CW-1:0] cmd);
      umi_cmd_t fields;
      fields.opcode  = cmd[7:0];
      fields.size    = cmd[11:8];
      fields.options = cmd[31:12];
      return fields;
   endfunction

   // Build a raw command from its fields
   function automatic logic [`UMI_CW-1:0] umi_pack_cmd(input logic [7:0]  opcode,
                                                      input logic [3:0]  size,
                                                      input logic [19:0] options);
      return {options, size, opcode};
   endfunction

endpackage

//--- dv/tb_top.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module tb_top
   import umi_pkg::*;
();

   // Transactions per test
   localparam int N_REG   = 32;
   localparam int N_SRAM  = 96;
   localparam int N_ID    = 4;
   localparam int N_UNMAP = 12;    // Four requests each
   localparam int N_FMT   = 40;
   localparam int N_MIX   = 120;
   localparam int TOTAL   = 2*N_REG + 2*N_SRAM + 2*N_ID + 4*N_UNMAP + N_FMT + N_MIX;
   localparam int TIMEOUT = 8*TOTAL + 100;

   logic      clk;
   logic      nreset;
   logic      udev_req_valid;
   umi_req_t  udev_req;
   logic      udev_req_ready;
   logic      udev_resp_valid;
   umi_resp_t udev_resp;
   logic      udev_resp_ready;
   int        pending;
   int        err_count;
   int        check_count;
   int        seed;
   int        cycles       = 0;
   int        tests_run    = 0;
   int        tests_failed = 0;
   bit        bp_on;               // Random response back-pressure
   bit        ok;

   umi_mem_subsys i_umi_mem_subsys (.*);
   umi_checker    i_umi_checker (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Hang guard
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT)
      begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   //####################################################################
   // Stimulus helpers
   //####################################################################

   task automatic set_resp_ready();
      udev_resp_ready = bp_on ? (($random(seed) & 3) != 0) : 1'b1;  // Low about one in four
   endtask

   // One request held until accepted, random size, options and source
   task automatic issue(input bit wr, input logic [1:0] region, input int idx);
      @(negedge clk);
      udev_req_valid                            = 1'b1;
      udev_req.cmd                              = $random(seed);
      udev_req.cmd[7:0]                         = wr ? `UMI_REQ_WRITE : `UMI_REQ_READ;
      udev_req.dstaddr                          = {$random(seed), $random(seed)};
      udev_req.dstaddr[`UMI_REGION_LSB +: 2]    = region;
      udev_req.dstaddr[`UMI_WORD_LSB +: 9]      = idx[8:0];
      udev_req.srcaddr                          = {$random(seed), $random(seed)};
      udev_req.data                             = {$random(seed), $random(seed)};
      set_resp_ready();
      @(posedge clk);
      while (!udev_req_ready)
      begin
         @(negedge clk);
         set_resp_ready();
         @(posedge clk);
      end
   endtask

   // Drain outstanding reads then report
   task automatic finish_test(input string name);
      @(negedge clk);
      udev_req_valid  = 1'b0;
      udev_resp_ready = 1'b1;
      while (pending != 0)
         @(negedge clk);
      i_umi_checker.report_test(name, ok);
      tests_run++;
      if (!ok)
         tests_failed++;
   endtask

   //####################################################################
   // Test sequence
   //####################################################################

   initial
   begin
      int region;
      int idx;
      seed            = 75430;
      nreset          = 1'b0;
      udev_req_valid  = 1'b0;
      udev_req        = '0;
      udev_resp_ready = 1'b1;
      bp_on           = 1'b0;
      repeat (2) @(posedge clk);   // Two clock edges in reset
      @(negedge clk);
      nreset = 1'b1;

      repeat (N_REG) issue(1'b1, 2'd0, 1 + {$random(seed)} % 15);   // Words 1 to 15
      repeat (N_REG) issue(1'b0, 2'd0, 1 + {$random(seed)} % 15);
      finish_test("regfile");

      repeat (N_SRAM) issue(1'b1, 2'd1, {$random(seed)} % `SRAM_DEPTH);
      repeat (N_SRAM) issue(1'b0, 2'd1, {$random(seed)} % `SRAM_DEPTH);
      finish_test("sram");

      repeat (N_ID)
      begin
         issue(1'b1, 2'd0, 0);
         issue(1'b0, 2'd0, 0);
      end
      finish_test("id_word");

      // Unmapped access, then same index in both targets
      repeat (N_UNMAP)
      begin
         region = 2 + ($random(seed) & 1);
         idx    = {$random(seed)} % `SRAM_DEPTH;
         issue(1'b1, region, idx);
         issue(1'b0, region, idx);
         issue(1'b0, 2'd0, idx);
         issue(1'b0, 2'd1, idx);
      end
      finish_test("unmapped");

      repeat (N_FMT)
      begin
         region = $random(seed) & 3;
         idx    = {$random(seed)} % `SRAM_DEPTH;
         issue(1'b0, region, idx);
      end
      finish_test("resp_format");

      bp_on = 1'b1;
      repeat (N_MIX)
      begin
         region = $random(seed) & 3;
         idx    = {$random(seed)} % `SRAM_DEPTH;
         issue($random(seed) & 1, region, idx);
      end
      bp_on = 1'b0;
      finish_test("backpressure");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, err_count);
      if ((tests_failed == 0) && (err_count == 0))
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- dv/umi_checker.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module umi_checker
   import umi_pkg::*;
(
   input  logic      clk,
   input  logic      nreset,
   input  logic      udev_req_valid,
   input  umi_req_t  udev_req,
   input  logic      udev_req_ready,
   input  logic      udev_resp_valid,
   input  umi_resp_t udev_resp,
   input  logic      udev_resp_ready,
   output int        pending,       // Reads still waiting for a response
   output int        err_count,
   output int        check_count
);

   localparam int RF_IDX_W = $clog2(`REGFILE_DEPTH);
   localparam int SR_IDX_W = $clog2(`SRAM_DEPTH);

   // Reference copies of both targets
   logic [`UMI_DW-1:0]  reg_model [0:`REGFILE_DEPTH-1];
   logic [`UMI_DW-1:0]  sram_model [0:`SRAM_DEPTH-1];
   umi_resp_t           exp_q [$];     // Expected responses in request order
   umi_resp_t           exp_rsp;
   umi_resp_t           held_rsp;      // Response stalled at the last edge
   logic                held;
   logic                read_prev;     // Read accepted at the last edge
   logic                sram_wr_prev;  // Scratch write accepted at the last edge
   logic [1:0]          region;
   logic [RF_IDX_W-1:0] rf_idx;
   logic [SR_IDX_W-1:0] sr_idx;
   int                  err_base = 0;  // Counts at the start of the current test
   int                  chk_base = 0;

   assign region = udev_req.dstaddr[`UMI_REGION_LSB +: 2];
   assign rf_idx = udev_req.dstaddr[`UMI_WORD_LSB +: RF_IDX_W];
   assign sr_idx = udev_req.dstaddr[`UMI_WORD_LSB +: SR_IDX_W];

   initial
   begin
      err_count   = 0;
      check_count = 0;
      pending     = 0;
   end

   task automatic expect_true(input bit cond, input string msg);
      check_count++;
      if (!cond)
      begin
         err_count++;
         $display("CHECK FAILED at %0t: %s", $time, msg);
      end
   endtask

   // Expected read data for an address, ID word and unmapped regions included
   function automatic logic [`UMI_DW-1:0] model_read(input logic [1:0] reg_sel,
                                                     input logic [RF_IDX_W-1:0] r_idx,
                                                     input logic [SR_IDX_W-1:0] s_idx);
      case (reg_sel)
         2'd0:    return (r_idx == '0) ? `UMI_ID_VALUE : reg_model[r_idx];
         2'd1:    return sram_model[s_idx];
         default: return '0;
      endcase
   endfunction

   //####################################################################
   // Scoreboard
   //####################################################################

   always @(posedge clk)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < `REGFILE_DEPTH; i++)
            reg_model[i] = '0;
         for (int i = 0; i < `SRAM_DEPTH; i++)
            sram_model[i] = '0;
         exp_q.delete();
         held         = 1'b0;
         read_prev    = 1'b0;
         sram_wr_prev = 1'b0;
      end
      else
      begin
         // Timing and stall rules
         if (read_prev)
            expect_true(udev_resp_valid, "response valid not high one cycle after read");
         if (held)
            expect_true(udev_resp_valid && (udev_resp == held_rsp),
                        "stalled response changed before it was taken");
         if (!udev_resp_ready)
            expect_true(!udev_req_ready, "request ready high while response ready low");
         if (sram_wr_prev && (region == 2'd1))
            expect_true(!udev_req_ready, "scratch memory ready high in recovery cycle");
         // Taken response against the oldest expected one
         if (udev_resp_valid && udev_resp_ready)
         begin
            if (exp_q.size() == 0)
               expect_true(1'b0, "response taken with no read outstanding");
            else
            begin
               exp_rsp = exp_q.pop_front();
               expect_true(udev_resp.cmd == exp_rsp.cmd,
                  $sformatf("resp cmd %h, expected %h", udev_resp.cmd, exp_rsp.cmd));
               expect_true(udev_resp.dstaddr == exp_rsp.dstaddr,
                  $sformatf("resp dstaddr %h, expected %h", udev_resp.dstaddr, exp_rsp.dstaddr));
               expect_true(udev_resp.srcaddr == '0,
                  $sformatf("resp srcaddr %h, expected zero", udev_resp.srcaddr));
               expect_true(udev_resp.data == exp_rsp.data,
                  $sformatf("resp data %h, expected %h", udev_resp.data, exp_rsp.data));
            end
         end
         held         = udev_resp_valid && !udev_resp_ready;
         held_rsp     = udev_resp;
         read_prev    = 1'b0;
         sram_wr_prev = 1'b0;
         // Accepted request updates the model or queues a response
         if (udev_req_valid && udev_req_ready)
         begin
            if (udev_req.cmd[7:0] == `UMI_REQ_WRITE)
            begin
               if ((region == 2'd0) && (rf_idx != '0))   // Word 0 is read only
                  reg_model[rf_idx] = udev_req.data;
               else if (region == 2'd1)
                  sram_model[sr_idx] = udev_req.data;
               sram_wr_prev = (region == 2'd1);
            end
            else
            begin
               exp_rsp.cmd     = {udev_req.cmd[31:8], `UMI_RESP_READ};  // Size, options echoed
               exp_rsp.dstaddr = udev_req.srcaddr;
               exp_rsp.srcaddr = '0;
               exp_rsp.data    = model_read(region, rf_idx, sr_idx);
               exp_q.push_back(exp_rsp);
               read_prev = 1'b1;
            end
         end
         pending = exp_q.size();
      end
   end

   // Per-test line, errors counted since the previous report
   task automatic report_test(input string name, output bit ok);
      ok = (err_count == err_base);
      $display("Test %s: %s, %0d checks, %0d errors", name, ok ? "passed" : "failed",
               check_count - chk_base, err_count - err_base);
      err_base = err_count;
      chk_base = check_count;
   endtask

endmodule

//--- tb.f
+incdir+design
design/umi_pkg.sv
design/umi_endpoint.sv
design/loc_target_combine.sv
design/loc_regfile.sv
design/loc_sram.sv
design/umi_mem_subsys.sv
dv/umi_checker.sv
dv/tb_top.sv
